/* include/conv_consts.svh */
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// size of the multiply-accumulate grid
`define ROWS 2
`define COLS 4

// pixels and weights share one signed width
`define WORD_WIDTH 8
`define WORD_WIDTH_ACC 24

// pipeline depths in enabled cycles
`define LATENCY_MULTIPLIER 2
`define LATENCY_ACCUMULATOR 1

`endif

/* design/conv_ctrl_pkg.sv */
`default_nettype none

package conv_ctrl_pkg;

  // position of a beat inside one accumulation group
  typedef enum logic [1:0] {
    OP_START  = 2'd0,
    OP_CONT   = 2'd1,
    OP_END    = 2'd2,
    OP_SINGLE = 2'd3 // starts and ends a sum on the same beat
  } beat_op_e;

  typedef enum logic {
    IDLE = 1'b0,
    SEND = 1'b1
  } ser_state_e;

endpackage

`default_nettype wire

/* design/conv_stream_pkg.sv */
`default_nettype none

`include "conv_consts.svh"

package conv_stream_pkg;

  typedef logic signed [`WORD_WIDTH-1:0] word_t;
  typedef logic signed [`WORD_WIDTH_ACC-1:0] acc_t;
  typedef logic [$clog2(`COLS)-1:0] col_idx_t;

  typedef word_t [`ROWS-1:0] pixel_vec_t;
  typedef word_t [`COLS-1:0] weight_vec_t;

  // one accumulator per row, as seen by a single weight column
  typedef acc_t [`ROWS-1:0] acc_col_t;

  typedef struct packed {
    pixel_vec_t               pixels;
    weight_vec_t              weights;
    conv_ctrl_pkg::beat_op_e  op;
  } in_beat_st;

  typedef struct packed {
    acc_col_t [`COLS-1:0] cols;
  } result_st;

  typedef struct packed {
    acc_col_t acc;
    col_idx_t col_index;
  } out_beat_st;

endpackage

`default_nettype wire

/* design/n_delay.sv */
`timescale 1ns/10ps
`default_nettype none

module n_delay #(
  parameter int N     = 1,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             clken,
  input  logic [WIDTH-1:0] data_in,
  output logic [WIDTH-1:0] data_out
);

  generate
    if (N == 0) begin : g_bypass
      assign data_out = data_in; // zero depth is a plain wire
    end else begin : g_shift
      logic [N-1:0][WIDTH-1:0] stages;

      always_ff @(posedge clk) begin
        if (rst) begin
          stages <= '0;
        end else if (clken) begin
          stages[0] <= data_in;
          for (int i = 1; i < N; i++) begin
            stages[i] <= stages[i-1];
          end
        end
      end

      assign data_out = stages[N-1];
    end
  endgenerate

endmodule

`default_nettype wire

/* design/pixel_input_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module pixel_input_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      clken,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  conv_stream_pkg::in_beat_st in_beat,
  output logic                      eng_valid,
  output conv_stream_pkg::in_beat_st eng_beat
);

  import conv_stream_pkg::*;

  in_beat_st skid_beat;
  logic      skid_valid;
  logic      push;
  logic      pop;
  logic      load_out;

  // ready comes straight from a flop so the upstream path stays short
  assign in_ready = !skid_valid;
  assign push     = in_valid && in_ready;
  assign pop      = eng_valid && clken;
  assign load_out = !eng_valid || pop; // output slot is empty or drains this cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      eng_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_out) begin
      eng_valid  <= skid_valid || push;
      skid_valid <= 1'b0;
    end else if (push) begin
      skid_valid <= 1'b1; // engine stalled, park the beat
    end
  end

  // a parked beat always goes out before anything newer
  always_ff @(posedge clk) begin
    if (load_out) begin
      eng_beat <= skid_valid ? skid_beat : in_beat;
    end
    if (!load_out && push) begin
      skid_beat <= in_beat;
    end
  end

endmodule

`default_nettype wire

/* design/processing_element.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module processing_element (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              clken,
  input  logic signed [`WORD_WIDTH-1:0]     pixel,
  input  logic signed [`WORD_WIDTH-1:0]     weight,
  input  logic                              mul_valid_in,
  input  logic                              start,
  output logic signed [`WORD_WIDTH_ACC-1:0] acc
);

  localparam int W     = `WORD_WIDTH;
  localparam int ACC_W = `WORD_WIDTH_ACC;
  localparam int LM    = `LATENCY_MULTIPLIER;

  logic                    nz;
  logic [2*W-1:0]          operands_q;
  logic signed [W-1:0]     pixel_q;
  logic signed [W-1:0]     weight_q;
  logic [1:0]              flags_q;
  logic signed [2*W-1:0]   prod;
  logic                    prod_valid;
  logic                    prod_nz;
  logic signed [ACC_W-1:0] prod_ext;

  assign nz = (|pixel) && (|weight);

  // all stages before the product register
  n_delay #(.N(LM-1), .WIDTH(2*W)) u_operands (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .data_in  ({pixel, weight}),
    .data_out (operands_q)
  );

  n_delay #(.N(LM-1), .WIDTH(2)) u_valid (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .data_in  ({mul_valid_in, nz}),
    .data_out (flags_q)
  );

  assign pixel_q  = operands_q[2*W-1:W];
  assign weight_q = operands_q[W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      prod_valid <= 1'b0;
      prod_nz    <= 1'b0;
    end else if (clken) begin
      prod_valid <= flags_q[1];
      prod_nz    <= flags_q[1] && flags_q[0];
    end
  end

  // a zero operand leaves the product register untouched
  always_ff @(posedge clk) begin
    if (clken && flags_q[1] && flags_q[0]) begin
      prod <= pixel_q * weight_q;
    end
  end

  always_comb begin
    prod_ext = '0;
    if (prod_nz) prod_ext = ACC_W'(prod); // sign extends, stale product is masked
  end

  always_ff @(posedge clk) begin
    if (clken && prod_valid) begin
      if (start) acc <= prod_ext;
      else       acc <= acc + prod_ext; // wraps at the accumulator width
    end
  end

endmodule

`default_nettype wire

/* design/conv_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module conv_engine (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clken,
  input  logic                       eng_valid,
  input  conv_stream_pkg::in_beat_st eng_beat,
  output logic                       res_pending,
  output logic                       res_valid,
  output conv_stream_pkg::result_st  res_grid
);

  import conv_ctrl_pkg::*;
  import conv_stream_pkg::*;

  localparam int ROWS = `ROWS;
  localparam int COLS = `COLS;
  localparam int LM   = `LATENCY_MULTIPLIER;
  localparam int LA   = `LATENCY_ACCUMULATOR;

  logic                 beat_start;
  logic                 beat_end;
  logic [2:0]           mul_ctrl;
  logic                 mul_valid;
  logic                 mul_start;
  logic                 mul_end;
  acc_col_t [COLS-1:0]  acc_grid;

  assign beat_start = (eng_beat.op == OP_START) || (eng_beat.op == OP_SINGLE);
  assign beat_end   = (eng_beat.op == OP_END) || (eng_beat.op == OP_SINGLE);

  // control travels with the operands so it lines up with the products
  n_delay #(.N(LM), .WIDTH(3)) u_mul_ctrl (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .data_in  ({eng_valid, beat_start, beat_end}),
    .data_out (mul_ctrl)
  );

  assign mul_valid = mul_ctrl[2];
  assign mul_start = mul_ctrl[1];
  assign mul_end   = mul_ctrl[0];

  // the last product of a sum is at the accumulator inputs
  assign res_pending = mul_valid && mul_end;

  n_delay #(.N(LA), .WIDTH(1)) u_acc_ctrl (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .data_in  (res_pending),
    .data_out (res_valid)
  );

  generate
    for (genvar c = 0; c < COLS; c++) begin : g_col
      for (genvar r = 0; r < ROWS; r++) begin : g_row
        processing_element u_pe (
          .clk          (clk),
          .rst          (rst),
          .clken        (clken),
          .pixel        (eng_beat.pixels[r]),
          .weight       (eng_beat.weights[c]),
          .mul_valid_in (eng_valid),
          .start        (mul_start),
          .acc          (acc_grid[c][r])
        );
      end
    end
  endgenerate

  assign res_grid.cols = acc_grid; // read straight off the accumulators

endmodule

`default_nettype wire

/* design/result_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module result_serializer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        res_valid,
  input  conv_stream_pkg::result_st   res_grid,
  output logic                        accept,
  output logic                        out_valid,
  output logic                        out_last,
  input  logic                        out_ready,
  output conv_stream_pkg::out_beat_st out_beat
);

  import conv_ctrl_pkg::*;
  import conv_stream_pkg::*;

  localparam int COLS = `COLS;

  ser_state_e state;
  col_idx_t   col;
  result_st   grid;
  logic       last_col;
  logic       capture;

  assign last_col  = (col == col_idx_t'(COLS-1));
  assign out_valid = (state == SEND);
  assign out_last  = out_valid && last_col;

  // free now, or free after the column leaving this cycle
  assign accept  = (state == IDLE) || (out_last && out_ready);
  assign capture = res_valid && accept;

  always_comb begin
    out_beat.acc       = grid.cols[col];
    out_beat.col_index = col;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      col   <= '0;
    end else if (capture) begin
      state <= SEND; // a new grid can follow the last column directly
      col   <= '0;
    end else if (out_valid && out_ready) begin
      if (last_col) state <= IDLE;
      col <= col + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      grid <= res_grid;
    end
  end

endmodule

`default_nettype wire

/* design/conv_top.sv */
`timescale 1ns/10ps
`default_nettype none

module conv_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  output logic                        in_ready,
  input  conv_stream_pkg::in_beat_st  in_beat,
  output logic                        out_valid,
  input  logic                        out_ready,
  output conv_stream_pkg::out_beat_st out_beat,
  output logic                        out_last
);

  import conv_stream_pkg::*;

  logic      clken;
  logic      eng_valid;
  in_beat_st eng_beat;
  logic      res_pending;
  logic      res_valid;
  result_st  res_grid;
  logic      accept;

  // the whole engine stalls only when a finished sum has nowhere to go
  assign clken = accept || !res_pending;

  pixel_input_stage u_input (
    .clk       (clk),
    .rst       (rst),
    .clken     (clken),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .eng_valid (eng_valid),
    .eng_beat  (eng_beat)
  );

  conv_engine u_engine (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .eng_valid   (eng_valid),
    .eng_beat    (eng_beat),
    .res_pending (res_pending),
    .res_valid   (res_valid),
    .res_grid    (res_grid)
  );

  result_serializer u_serializer (
    .clk       (clk),
    .rst       (rst),
    .res_valid (res_valid),
    .res_grid  (res_grid),
    .accept    (accept),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

endmodule

`default_nettype wire

/* verification/conv_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv_consts.svh"

module conv_tb;

  import conv_ctrl_pkg::*;
  import conv_stream_pkg::*;

  localparam int ROWS        = `ROWS;
  localparam int COLS        = `COLS;
  localparam int N_WRAP      = 520; // enough full-scale products to wrap a 24-bit sum
  localparam int N_PARK      = 20; // beats offered with the output held, ahead of the reset
  localparam int TOTAL_BEATS = 1 + 12 + N_WRAP + 12 + 30 + N_PARK;

  logic       clk, rst, in_valid, in_ready, out_valid, out_ready, out_last;
  in_beat_st  in_beat;
  out_beat_st out_beat;
  integer     seed;
  int         errors, checks, tests, reported;
  logic       saw_stall;
  logic       sending;
  in_beat_st  tx_q[$];
  out_beat_st exp_q[$];

  conv_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (TOTAL_BEATS * 20) @(posedge clk);
    $display("timeout, the run did not end within %0d cycles", TOTAL_BEATS * 20);
    $display("Testbench failed");
    $finish;
  end

  task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
    end
  endtask

  // values are stable at the falling edge and a beat moves on the next rising edge
  always @(negedge clk) begin : monitor
    out_beat_st want;
    if (!rst && !in_ready) saw_stall = 1'b1;
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("an output beat arrived with nothing left to expect");
      end else begin
        want = exp_q.pop_front();
        for (int r = 0; r < ROWS; r++) begin
          check_value($sformatf("out_beat.acc[%0d]", r), out_beat.acc[r], want.acc[r]);
        end
        check_value("out_beat.col_index", out_beat.col_index, want.col_index);
        check_value("out_last", out_last, want.col_index == col_idx_t'(COLS - 1));
      end
    end
  end

  function automatic word_t random_word();
    if (($random(seed) & 3) == 0) return '0; // about a quarter of the operands are zero
    return word_t'($random(seed));
  endfunction

  // one group of beats for the sender, and the columns the reference sum gives for it
  task automatic queue_group(int n, logic wrap);
    in_beat_st  b;
    out_beat_st col_beat;
    acc_t       sum [COLS][ROWS];
    int         prod;
    sum = '{default: '0};
    for (int i = 0; i < n; i++) begin
      b.op = (n == 1) ? OP_SINGLE : (i == 0) ? OP_START : (i == n - 1) ? OP_END : OP_CONT;
      for (int r = 0; r < ROWS; r++) begin
        b.pixels[r] = wrap ? word_t'((r % 2 == 1) ? 127 : -128) : random_word();
      end
      for (int c = 0; c < COLS; c++) begin
        b.weights[c] = wrap ? word_t'(-128) : random_word();
        for (int r = 0; r < ROWS; r++) begin
          prod = $signed(b.pixels[r]) * $signed(b.weights[c]);
          sum[c][r] = sum[c][r] + acc_t'(prod); // wraps at 24 bits like the hardware sum
        end
      end
      tx_q.push_back(b);
    end
    for (int c = 0; c < COLS; c++) begin
      for (int r = 0; r < ROWS; r++) col_beat.acc[r] = sum[c][r];
      col_beat.col_index = col_idx_t'(c);
      exp_q.push_back(col_beat);
    end
  endtask

  // beats go out back to back, each one held until in_ready takes it
  task automatic send_queued();
    logic taken;
    while (tx_q.size() != 0) begin
      in_valid = 1'b1;
      in_beat  = tx_q.pop_front();
      taken    = 1'b0;
      while (!taken) begin
        @(negedge clk);
        taken = in_ready;
        @(posedge clk);
        #10;
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic finish_test(string name);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 400) begin
      @(posedge clk);
      #10;
      cycles++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: %0d expected output beats never arrived", name, exp_q.size());
      exp_q.delete();
    end
    tests++;
    $display("%s: %0d errors", name, errors - reported);
    reported = errors;
  endtask

  task automatic single_beat();
    queue_group(1, 1'b0);
    send_queued();
    finish_test("single beat");
  endtask

  task automatic long_groups_wrap();
    queue_group(12, 1'b0);
    queue_group(N_WRAP, 1'b1);
    send_queued();
    finish_test("long groups with wrap");
  endtask

  task automatic back_to_back_groups();
    queue_group(5, 1'b0);
    queue_group(4, 1'b0);
    queue_group(3, 1'b0);
    send_queued();
    finish_test("back to back groups");
  endtask

  task automatic output_back_pressure();
    int len;
    saw_stall = 1'b0;
    for (int g = 0; g < 6; g++) queue_group(5, 1'b0);
    sending = 1'b1;
    fork
      begin
        send_queued();
        sending = 1'b0;
      end
      begin
        out_ready = 1'b0;
        len = 25; // long first stretch so the input side fills up
        while (sending) begin
          repeat (len) begin
            @(posedge clk);
            #10;
          end
          out_ready = !out_ready;
          len = 1 + ($random(seed) & 7);
        end
        out_ready = 1'b1;
      end
    join
    if (!saw_stall) begin
      errors++;
      $display("back pressure: in_ready never went low while outputs were held");
    end
    finish_test("back pressure");
  endtask

  task automatic reset_and_idle();
    logic seen;
    // a grid waits in the serializer and the skid buffer is full when reset hits
    out_ready  = 1'b0;
    in_beat.op = OP_SINGLE;
    in_valid   = 1'b1;
    repeat (N_PARK) begin
      @(posedge clk);
      #10;
    end
    @(negedge clk);
    check_value("out_valid before reset", out_valid, 1);
    check_value("in_ready before reset", in_ready, 0);
    @(posedge clk);
    #10;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    rst       = 1'b1;
    repeat (4) begin
      @(posedge clk);
      #10;
    end
    rst = 1'b0;
    @(negedge clk);
    check_value("out_valid", out_valid, 0);
    check_value("out_last", out_last, 0);
    check_value("in_ready", in_ready, 1);
    seen = 1'b0;
    repeat (40) begin
      @(negedge clk);
      seen = seen | out_valid;
    end
    check_value("out_valid while idle", seen, 0);
    @(posedge clk);
    #10;
    finish_test("reset and idle");
  endtask

  initial begin
    seed      = 32'hc69;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    reported  = 0;
    saw_stall = 1'b0;
    sending   = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b1;
    repeat (4) @(posedge clk);
    #10;
    rst = 1'b0;
    single_beat();
    long_groups_wrap();
    back_to_back_groups();
    output_back_pressure();
    reset_and_idle();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
design/conv_ctrl_pkg.sv
design/conv_stream_pkg.sv
design/n_delay.sv
design/pixel_input_stage.sv
design/processing_element.sv
design/conv_engine.sv
design/result_serializer.sv
design/conv_top.sv
verification/conv_tb.sv

/* Makefile */
TOP       ?= conv_tb
FLIST     ?= build.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "PASS: $(TOP)"; \
	else \
	  echo "FAIL: $(TOP), see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
